// ==== hw/exePkg.sv ====
`default_nettype none

package exePkg;

    localparam int dataWidth = 32;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [3:0] regIdxT;
    typedef logic signed [15:0] immT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    typedef enum logic [1:0] {
        opAlu,
        opLoad,
        opStore,
        opBranch
    } opClassT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNot,
        aluMov, aluMovt, aluClr, aluSet, aluLsl, aluLsr
    } aluOpT;

    // Encoding 15 is unused
    typedef enum logic [3:0] {
        EQ, NE, HS, LO, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL
    } condT;

    typedef struct packed {
        opClassT opClass;
        aluOpT aluOp;
        condT cond;
        logic useImm;      // Operand two from imm instead of rs2
        logic setFlags;
        regIdxT rd;        // Also the store data register
        regIdxT rs1;
        regIdxT rs2;
        immT imm;
    } instT;

    // Register write request and report
    typedef struct packed {
        logic valid;
        regIdxT rd;
        dataT data;
    } wbT;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        dataT paddr;
        dataT pwdata;
    } apbReqT;

endpackage

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile #(
    parameter int numRegs = 16
) (
    input wire clk,
    input wire rst,
    input wire exePkg::regIdxT rs1,
    input wire exePkg::regIdxT rs2,
    input wire exePkg::regIdxT rd,
    output exePkg::dataT rs1Data,
    output exePkg::dataT rs2Data,
    output exePkg::dataT rdData,
    input wire exePkg::wbT aluWb,
    input wire exePkg::wbT loadWb,
    output exePkg::wbT wb
);
    import exePkg::*;

    dataT regs [numRegs];
    wbT wr;

    assign wr = aluWb.valid ? aluWb : loadWb;

    // Indices past numRegs read as zero
    assign rs1Data = (rs1 < numRegs) ? regs[rs1] : '0;
    assign rs2Data = (rs2 < numRegs) ? regs[rs2] : '0;
    assign rdData = (rd < numRegs) ? regs[rd] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
            wb <= '0;
        end else begin
            if (wr.valid && wr.rd < numRegs) begin
                regs[wr.rd] <= wr.data;
            end
            wb <= wr;  // Report lags the write by one cycle
        end
    end

    // ALU writes only on accept, which the sequencer blocks during a load
    singleWriter: assert property (@(posedge clk) disable iff (rst)
        !(aluWb.valid && loadWb.valid))
        else $error("regFile: ALU and load write in the same cycle");

endmodule

`default_nettype wire

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input wire accept,
    input wire exePkg::instT inst,
    input wire exePkg::dataT rs1Data,
    input wire exePkg::dataT rs2Data,
    input wire exePkg::dataT rdData,
    input wire exePkg::flagsT flagsIn,
    output exePkg::wbT aluWb,
    output exePkg::flagsT flagsNext,
    output logic flagsWrite,
    output exePkg::dataT addrSum
);
    import exePkg::*;

    localparam int msb = dataWidth - 1;

    dataT immExt;
    dataT opB;
    dataT result;
    logic [dataWidth:0] sum;   // Carry out in top bit
    logic [dataWidth:0] diff;  // Borrow out in top bit
    logic negRes;
    logic zeroRes;
    logic isAlu;

    assign immExt = {{(dataWidth - 16){inst.imm[15]}}, inst.imm};
    assign opB = inst.useImm ? immExt : rs2Data;

    assign sum = {1'b0, rs1Data} + {1'b0, opB};
    assign diff = {1'b0, rs1Data} - {1'b0, opB};

    // Load/store address and register-relative jump target
    assign addrSum = rs1Data + immExt;

    always_comb begin
        case (inst.aluOp)
            aluAdd:  result = sum[msb:0];
            aluSub:  result = diff[msb:0];
            aluAnd:  result = rs1Data & opB;
            aluOr:   result = rs1Data | opB;
            aluXor:  result = rs1Data ^ opB;
            aluNot:  result = ~rs1Data;
            aluMov:  result = opB;
            aluMovt: result = {inst.imm, rdData[15:0]};  // Upper half only
            aluClr:  result = '0;
            aluSet:  result = '1;
            aluLsl:  result = rs1Data << opB;  // Large shift counts give zero
            aluLsr:  result = rs1Data >> opB;
            default: result = '0;
        endcase
    end

    assign negRes = result[msb];
    assign zeroRes = (result == '0);

    always_comb begin
        flagsNext = flagsIn;
        case (inst.aluOp)
            aluAdd: begin
                flagsNext.n = negRes;
                flagsNext.z = zeroRes;
                flagsNext.c = sum[dataWidth];
                flagsNext.v = ~(rs1Data[msb] ^ opB[msb]) & (rs1Data[msb] ^ result[msb]);
            end
            aluSub: begin
                flagsNext.n = negRes;
                flagsNext.z = zeroRes;
                flagsNext.c = ~diff[dataWidth];  // C is no borrow
                flagsNext.v = (rs1Data[msb] ^ opB[msb]) & (rs1Data[msb] ^ result[msb]);
            end
            aluAnd, aluOr, aluXor, aluNot: begin
                flagsNext.n = negRes;  // C and V kept
                flagsNext.z = zeroRes;
            end
            default: flagsNext = flagsIn;
        endcase
    end

    assign isAlu = accept && (inst.opClass == opAlu);
    assign flagsWrite = isAlu && inst.setFlags;
    assign aluWb = '{valid: isAlu, rd: inst.rd, data: result};

endmodule

`default_nettype wire

// ==== hw/flagUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module flagUnit (
    input wire clk,
    input wire rst,
    input wire accept,
    input wire exePkg::instT inst,
    input wire exePkg::flagsT flagsNext,
    input wire flagsWrite,
    input wire exePkg::dataT addrSum,
    output exePkg::flagsT flags,
    output logic branchValid,
    output logic branchTaken,
    output exePkg::dataT branchTarget
);
    import exePkg::*;

    logic condMet;
    logic isBranch;

    assign isBranch = accept && (inst.opClass == opBranch);

    // ARM condition codes on the current NZCV
    always_comb begin
        case (inst.cond)
            EQ: condMet = flags.z;
            NE: condMet = !flags.z;
            HS: condMet = flags.c;
            LO: condMet = !flags.c;
            MI: condMet = flags.n;
            PL: condMet = !flags.n;
            VS: condMet = flags.v;
            VC: condMet = !flags.v;
            HI: condMet = flags.c && !flags.z;
            LS: condMet = !flags.c || flags.z;
            GE: condMet = (flags.n == flags.v);
            LT: condMet = (flags.n != flags.v);
            GT: condMet = !flags.z && (flags.n == flags.v);
            LE: condMet = flags.z || (flags.n != flags.v);
            AL: condMet = 1'b1;
            default: condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
            branchValid <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            if (flagsWrite) begin
                flags <= flagsNext;
            end
            branchValid <= isBranch;  // One-cycle pulse
            branchTaken <= isBranch && condMet;
        end
    end

    // Conditional branches jump to the immediate, AL is register-relative
    always_ff @(posedge clk) begin
        if (isBranch) begin
            branchTarget <= (inst.cond == AL) ? addrSum
                                              : {{(dataWidth - 16){inst.imm[15]}}, inst.imm};
        end
    end

endmodule

`default_nettype wire

// ==== hw/memSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSequencer (
    input wire clk,
    input wire rst,
    input wire exePkg::instT inst,
    input wire instValid,
    output logic instReady,
    output logic accept,
    input wire exePkg::dataT addrSum,
    input wire exePkg::dataT rdData,
    output exePkg::apbReqT apbReq,
    input wire exePkg::dataT prdata,
    input wire pready,
    output exePkg::wbT loadWb
);
    import exePkg::*;

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } stateT;

    stateT state;
    logic isMem;
    logic done;
    dataT addrReg;
    dataT dataReg;
    logic writeReg;
    regIdxT loadRd;

    // Only back-pressure in the stage
    assign instReady = (state == idle);
    assign accept = instValid && instReady;

    assign isMem = (inst.opClass == opLoad) || (inst.opClass == opStore);
    assign done = (state == access) && pready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (accept && isMem) state <= setup;
                setup:   state <= access;
                access:  if (pready) state <= idle;  // Wait states hold here
                default: state <= idle;
            endcase
        end
    end

    // Transfer fields held from setup to completion
    always_ff @(posedge clk) begin
        if (accept && isMem) begin
            addrReg <= addrSum;
            dataReg <= rdData;
            writeReg <= (inst.opClass == opStore);
            loadRd <= inst.rd;
        end
    end

    assign apbReq = '{psel: (state != idle), penable: (state == access), pwrite: writeReg,
                      paddr: addrReg, pwdata: dataReg};

    assign loadWb = '{valid: done && !writeReg, rd: loadRd, data: prdata};

    penableWithPsel: assert property (@(posedge clk) disable iff (rst)
        apbReq.penable |-> apbReq.psel)
        else $error("memSequencer: penable without psel");

    addrStable: assert property (@(posedge clk) disable iff (rst)
        (apbReq.psel && !done) |=> $stable(apbReq.paddr) && $stable(apbReq.pwrite)
                                   && $stable(apbReq.pwdata))
        else $error("memSequencer: APB request changed during transfer");

endmodule

`default_nettype wire

// ==== hw/exeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exeUnit #(
    parameter int numRegs = 16
) (
    input wire clk,
    input wire rst,
    input wire exePkg::instT inst,
    input wire instValid,
    output logic instReady,
    output exePkg::apbReqT apbReq,
    input wire exePkg::dataT prdata,
    input wire pready,
    output exePkg::wbT wb,
    output exePkg::flagsT flags,
    output logic branchValid,
    output logic branchTaken,
    output exePkg::dataT branchTarget
);
    import exePkg::*;

    logic accept;  // Issue handshake from the sequencer
    dataT rs1Data;
    dataT rs2Data;
    dataT rdData;
    dataT addrSum;
    wbT aluWb;
    wbT loadWb;
    flagsT flagsNext;
    logic flagsWrite;

    regFile #(.numRegs(numRegs)) regFile0 (
        .clk(clk),
        .rst(rst),
        .rs1(inst.rs1),
        .rs2(inst.rs2),
        .rd(inst.rd),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .rdData(rdData),
        .aluWb(aluWb),
        .loadWb(loadWb),
        .wb(wb)
    );

    aluUnit aluUnit0 (
        .accept(accept),
        .inst(inst),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .rdData(rdData),
        .flagsIn(flags),
        .aluWb(aluWb),
        .flagsNext(flagsNext),
        .flagsWrite(flagsWrite),
        .addrSum(addrSum)
    );

    flagUnit flagUnit0 (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .inst(inst),
        .flagsNext(flagsNext),
        .flagsWrite(flagsWrite),
        .addrSum(addrSum),
        .flags(flags),
        .branchValid(branchValid),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    memSequencer memSequencer0 (
        .clk(clk),
        .rst(rst),
        .inst(inst),
        .instValid(instValid),
        .instReady(instReady),
        .accept(accept),
        .addrSum(addrSum),
        .rdData(rdData),
        .apbReq(apbReq),
        .prdata(prdata),
        .pready(pready),
        .loadWb(loadWb)
    );

endmodule

`default_nettype wire

// ==== tb/tbModel.svh ====
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

// Model state, updated in issue order by the stimulus
dataT modelRegs [16];
flagsT modelFlags;
dataT modelMem [64];  // Word addressed by paddr[7:2]

function automatic dataT sext(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
endfunction

// Expected ALU result and flags for one instruction
function automatic void refAlu(input instT i, output dataT res, output flagsT fl);
    dataT a;
    dataT b;
    logic [32:0] wide;
    a = modelRegs[i.rs1];
    b = i.useImm ? sext(i.imm) : modelRegs[i.rs2];
    fl = modelFlags;
    res = '0;
    case (i.aluOp)
        aluAdd: begin
            wide = {1'b0, a} + {1'b0, b};
            res = wide[31:0];
            fl.c = wide[32];
            fl.v = (a[31] == b[31]) && (res[31] != a[31]);  // Same signs in, other sign out
        end
        aluSub: begin
            res = a - b;
            fl.c = (a >= b);
            fl.v = (a[31] != b[31]) && (res[31] != a[31]);
        end
        aluAnd: res = a & b;
        aluOr: res = a | b;
        aluXor: res = a ^ b;
        aluNot: res = ~a;
        aluMov: res = b;
        aluMovt: res = {i.imm, modelRegs[i.rd][15:0]};
        aluClr: res = '0;
        aluSet: res = 32'hffff_ffff;
        aluLsl: res = (b > 31) ? '0 : (a << b[4:0]);
        aluLsr: res = (b > 31) ? '0 : (a >> b[4:0]);
        default: res = '0;
    endcase
    if (i.aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNot}) begin
        fl.n = res[31];
        fl.z = (res == 0);
    end
endfunction

function automatic logic condHolds(input condT cd, input flagsT f);
    case (cd)
        EQ: return f.z;
        NE: return !f.z;
        HS: return f.c;
        LO: return !f.c;
        MI: return f.n;
        PL: return !f.n;
        VS: return f.v;
        VC: return !f.v;
        HI: return f.c && !f.z;
        LS: return !(f.c && !f.z);
        GE: return f.n == f.v;
        LT: return f.n != f.v;
        GT: return !f.z && (f.n == f.v);
        LE: return f.z || (f.n != f.v);
        default: return 1'b1;  // AL
    endcase
endfunction

`endif

// ==== tb/exeUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exeUnitTb;
    import exePkg::*;

    logic clk;
    logic rst;
    instT inst;
    logic instValid;
    logic instReady;
    apbReqT apbReq;
    dataT prdata;
    logic pready;
    wbT wb;
    flagsT flags;
    logic branchValid;
    logic branchTaken;
    dataT branchTarget;

    integer stimSeed;
    integer waitSeed;
    int errors;
    int checks;
    logic hung;
    int waitLeft;
    dataT mem [64];

    wbT expWb [$];
    flagsT expFl [$];
    logic [32:0] expBr [$];  // Taken bit over target

    `include "tbModel.svh"

    exeUnit #(.numRegs(16)) dut0 (
        .clk(clk),
        .rst(rst),
        .inst(inst),
        .instValid(instValid),
        .instReady(instReady),
        .apbReq(apbReq),
        .prdata(prdata),
        .pready(pready),
        .wb(wb),
        .flags(flags),
        .branchValid(branchValid),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    always #2 clk = ~clk;

    // APB slave with 0 to 3 wait states
    always @(negedge clk) begin
        if (apbReq.psel && !apbReq.penable) begin
            waitLeft = $random(waitSeed) & 3;
            pready = 1'b0;
        end else if (apbReq.psel && apbReq.penable && !pready) begin
            if (waitLeft == 0) begin
                pready = 1'b1;
                prdata = mem[apbReq.paddr[7:2]];
                if (apbReq.pwrite) mem[apbReq.paddr[7:2]] = apbReq.pwdata;
            end else begin
                waitLeft--;
            end
        end else begin
            pready = 1'b0;
        end
    end

    // Compares DUT outputs where they are stable
    always @(negedge clk) begin
        wbT ew;
        flagsT ef;
        logic [32:0] eb;
        if (!rst) begin
            if (apbReq.psel) begin
                checks++;
                assert (!instReady) else begin
                    errors++;
                    $display("instReady went high during an APB transfer");
                end
            end
            if (wb.valid) begin
                if (expWb.size() == 0) begin
                    errors++;
                    $display("write-back seen with nothing expected");
                end else begin
                    ew = expWb.pop_front();
                    ef = expFl.pop_front();
                    checks += 2;
                    assert (wb === ew) else begin
                        errors++;
                        $display("error: wb expected %h got %h", ew, wb);
                    end
                    assert (flags === ef) else begin
                        errors++;
                        $display("error: flags expected %h got %h", ef, flags);
                    end
                end
            end
            if (branchValid) begin
                if (expBr.size() == 0) begin
                    errors++;
                    $display("branch outcome seen with nothing expected");
                end else begin
                    eb = expBr.pop_front();
                    checks += 2;
                    assert (branchTaken === eb[32]) else begin
                        errors++;
                        $display("error: branchTaken expected %h got %h", eb[32], branchTaken);
                    end
                    assert (branchTarget === eb[31:0]) else begin
                        errors++;
                        $display("error: branchTarget expected %h got %h", eb[31:0],
                                 branchTarget);
                    end
                end
            end
        end
    end

    function automatic instT makeInst(input opClassT oc, input aluOpT op, input condT cd,
                                      input logic ui, input logic sf, input regIdxT rd,
                                      input regIdxT rs1, input regIdxT rs2,
                                      input logic [15:0] imm);
        instT i;
        i.opClass = oc;
        i.aluOp = op;
        i.cond = cd;
        i.useImm = ui;
        i.setFlags = sf;
        i.rd = rd;
        i.rs1 = rs1;
        i.rs2 = rs2;
        i.imm = imm;
        return i;
    endfunction

    // Issues on the falling edge and records what the DUT should report
    task automatic applyInst(input instT i);
        int t;
        dataT res;
        flagsT fl;
        dataT addr;
        t = 0;
        while (!instReady && !hung && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (!instReady && !hung) begin
            hung = 1'b1;
            errors++;
            $display("timeout: instReady stayed low for 50 cycles");
        end
        if (!hung) begin
            addr = modelRegs[i.rs1] + sext(i.imm);
            case (i.opClass)
                opAlu: begin
                    refAlu(i, res, fl);
                    modelRegs[i.rd] = res;
                    if (i.setFlags) modelFlags = fl;
                    expWb.push_back('{valid: 1'b1, rd: i.rd, data: res});
                    expFl.push_back(modelFlags);
                end
                opStore: modelMem[addr[7:2]] = modelRegs[i.rd];
                opLoad: begin
                    modelRegs[i.rd] = modelMem[addr[7:2]];
                    expWb.push_back('{valid: 1'b1, rd: i.rd, data: modelRegs[i.rd]});
                    expFl.push_back(modelFlags);
                end
                default: expBr.push_back({condHolds(i.cond, modelFlags),
                                          (i.cond == AL) ? addr : sext(i.imm)});
            endcase
            inst = i;
            instValid = 1'b1;
            @(negedge clk);  // Accepted on the rising edge in between
            instValid = 1'b0;
            if (i.opClass == opAlu) begin  // Report due one cycle after accept
                checks++;
                assert (wb.valid) else begin
                    errors++;
                    $display("no write-back in the cycle after an ALU instruction");
                end
            end else if (i.opClass == opBranch) begin
                checks++;
                assert (branchValid) else begin
                    errors++;
                    $display("no branch outcome in the cycle after a branch");
                end
            end
        end
    endtask

    task automatic loadConst(input regIdxT rd, input dataT value);
        applyInst(makeInst(opAlu, aluMov, AL, 1'b1, 1'b0, rd, 4'd0, 4'd0, value[15:0]));
        applyInst(makeInst(opAlu, aluMovt, AL, 1'b1, 1'b0, rd, 4'd0, 4'd0, value[31:16]));
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "FAILED");
    endtask

    initial begin
        int e;
        int t;
        dataT a;
        dataT b;
        logic [31:0] corners [8];
        clk = 1'b0;
        rst = 1'b1;
        inst = '0;
        instValid = 1'b0;
        prdata = '0;
        pready = 1'b0;
        stimSeed = 32'h3e0b;
        waitSeed = 32'h3e0b;
        errors = 0;
        checks = 0;
        hung = 1'b0;
        waitLeft = 0;
        modelFlags = '0;
        for (int k = 0; k < 16; k++) modelRegs[k] = '0;
        for (int k = 0; k < 64; k++) begin
            mem[k] = 32'h5a00_0000 ^ (k * 32'h0103_0507);
            modelMem[k] = mem[k];
        end
        corners = '{32'h7fff_ffff, 32'h1, 32'h8000_0000, 32'h1,
                    32'hffff_ffff, 32'h1, 32'h0, 32'h1};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e = errors;
        applyInst(makeInst(opAlu, aluMov, AL, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 16'h1234));
        applyInst(makeInst(opAlu, aluMovt, AL, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 16'hbeef));
        applyInst(makeInst(opAlu, aluClr, AL, 1'b0, 1'b0, 4'd2, 4'd0, 4'd0, 16'h0));
        applyInst(makeInst(opAlu, aluSet, AL, 1'b0, 1'b0, 4'd3, 4'd0, 4'd0, 16'h0));
        applyInst(makeInst(opAlu, aluMov, AL, 1'b1, 1'b0, 4'd4, 4'd0, 4'd0, 16'h4));
        applyInst(makeInst(opAlu, aluLsl, AL, 1'b0, 1'b0, 4'd5, 4'd1, 4'd4, 16'h0));
        applyInst(makeInst(opAlu, aluLsr, AL, 1'b1, 1'b0, 4'd6, 4'd3, 4'd0, 16'd28));
        applyInst(makeInst(opAlu, aluLsl, AL, 1'b1, 1'b0, 4'd7, 4'd3, 4'd0, 16'd40));
        reportTest("moves and shifts", e);

        e = errors;
        for (int k = 0; k < 24; k++) begin
            a = (k < 4) ? corners[2 * k] : $random(stimSeed);
            b = (k < 4) ? corners[2 * k + 1] : $random(stimSeed);
            loadConst(4'd1, a);
            loadConst(4'd2, b);
            applyInst(makeInst(opAlu, (k % 2) ? aluSub : aluAdd, AL, 1'b0, !k[2],
                               4'd3, 4'd1, 4'd2, 16'h0));
            applyInst(makeInst(opAlu, aluSub, AL, 1'b0, 1'b1, 4'd3, 4'd2, 4'd1, 16'h0));
        end
        reportTest("add and sub", e);

        e = errors;
        loadConst(4'd1, 32'h8000_0000);
        applyInst(makeInst(opAlu, aluAdd, AL, 1'b0, 1'b1, 4'd2, 4'd1, 4'd1, 16'h0));
        applyInst(makeInst(opAlu, aluAnd, AL, 1'b1, 1'b1, 4'd3, 4'd1, 4'd0, 16'hffff));
        applyInst(makeInst(opAlu, aluOr, AL, 1'b1, 1'b1, 4'd3, 4'd3, 4'd0, 16'h00f0));
        applyInst(makeInst(opAlu, aluXor, AL, 1'b0, 1'b1, 4'd3, 4'd3, 4'd3, 16'h0));
        applyInst(makeInst(opAlu, aluNot, AL, 1'b0, 1'b1, 4'd4, 4'd3, 4'd0, 16'h0));
        for (int k = 0; k < 6; k++) begin  // Each one reads the previous result
            applyInst(makeInst(opAlu, aluAdd, AL, 1'b1, 1'b0, 4'd4, 4'd4, 4'd0, 16'h0003));
        end
        reportTest("logic and dependencies", e);

        e = errors;
        for (int k = 0; k < 5; k++) begin
            a = (k == 4) ? 32'h8000_0000 : 32'd5;
            b = (k < 2) ? 32'd5 - 2 * k : (k == 4 ? 32'd1 : 32'd9);
            loadConst(4'd1, a);
            loadConst(4'd2, b);
            applyInst(makeInst(opAlu, aluSub, AL, 1'b0, 1'b1, 4'd15, 4'd1, 4'd2, 16'h0));
            for (int c = 0; c < 15; c++) begin
                applyInst(makeInst(opBranch, aluAdd, condT'(c), 1'b0, 1'b0, 4'd0, 4'd1,
                                   4'd0, 16'h8000 + 16'(c * 4)));
            end
        end
        reportTest("branches", e);

        e = errors;
        loadConst(4'd8, 32'h40);
        for (int k = 0; k < 8; k++) begin
            loadConst(4'd7, $random(stimSeed));
            applyInst(makeInst(opStore, aluAdd, AL, 1'b0, 1'b0, 4'd7, 4'd8, 4'd0,
                               16'(k * 4 - 16)));
            applyInst(makeInst(opLoad, aluAdd, AL, 1'b0, 1'b0, 4'd9, 4'd8, 4'd0,
                               16'(k * 4 - 16)));
        end
        reportTest("store and load", e);

        t = 0;
        while ((expWb.size() != 0 || expBr.size() != 0) && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (expWb.size() != 0 || expBr.size() != 0) begin
            hung = 1'b1;
            $display("timeout: expected outputs never appeared");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !hung) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
hw/exePkg.sv
hw/regFile.sv
hw/aluUnit.sv
hw/flagUnit.sv
hw/memSequencer.sv
hw/exeUnit.sv
tb/exeUnitTb.sv

// ==== run.sh ====
#!/bin/bash
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module exeUnitTb \
    -o exeSim > build.log 2>&1 \
    && ./obj_dir/exeSim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }
